//--- tb/mem_wb_input.txt
// val we_rf sel_mem sx_op req_val req_we req_size rd alu_result store_data bp_sel io_rdata
// then expected rf_we rf_rd rf_wdata io_req_val io_we io_addr io_wdata, all hex
// cacheable word stores and loads
1 0 0 0 1 1 2 00 00000100 11223344 0 00000000  0 00 00000100 0 0 00000000 00000000
1 0 0 0 1 1 2 00 00000104 A5B6C7D8 0 00000000  0 00 00000104 0 0 00000000 00000000
1 1 1 2 1 0 2 01 00000100 00000000 0 00000000  1 01 11223344 0 0 00000000 00000000
1 1 1 2 1 0 2 02 00000104 00000000 0 00000000  1 02 A5B6C7D8 0 0 00000000 00000000
// byte store into a written word
1 0 0 0 1 1 0 00 00000101 000000EE 0 00000000  0 00 00000101 0 0 00000000 00000000
1 1 1 4 1 0 0 03 00000101 00000000 0 00000000  1 03 000000EE 0 0 00000000 00000000
1 1 1 0 1 0 0 04 00000101 00000000 0 00000000  1 04 FFFFFFEE 0 0 00000000 00000000
1 1 1 2 1 0 2 05 00000100 00000000 0 00000000  1 05 1122EE44 0 0 00000000 00000000
// halfword store and extended loads
1 0 0 0 1 1 1 00 00000106 00009988 0 00000000  0 00 00000106 0 0 00000000 00000000
1 1 1 1 1 0 1 06 00000106 00000000 0 00000000  1 06 FFFF9988 0 0 00000000 00000000
1 1 1 5 1 0 1 07 00000106 00000000 0 00000000  1 07 00009988 0 0 00000000 00000000
1 1 1 1 1 0 1 08 00000104 00000000 0 00000000  1 08 FFFFC7D8 0 0 00000000 00000000
1 1 1 0 1 0 0 09 00000103 00000000 0 00000000  1 09 00000011 0 0 00000000 00000000
1 1 1 5 1 0 1 0A 00000102 00000000 0 00000000  1 0A 00001122 0 0 00000000 00000000
// alu result, then uncached store of it through the bypass
1 1 0 0 0 0 0 0B 12345678 00000000 0 00000000  1 0B 12345678 0 0 00000000 00000000
1 0 0 0 1 1 2 00 F0000010 BAD0BAD0 1 00000000  0 00 F0000010 1 1 F0000010 12345678
// uncached loads
1 1 1 2 1 0 2 0C F0000100 00000000 0 CAFEF00D  1 0C CAFEF00D 1 0 F0000100 00000000
1 1 1 0 1 0 0 0D F0000103 00000000 0 80FFFFFF  1 0D FFFFFF80 1 0 F0000103 00000000
1 1 1 5 1 0 1 0E F0000106 00000000 0 80FF1234  1 0E 000080FF 1 0 F0000106 00000000
// cacheable loads at the same low bits ignore io data
1 1 1 2 1 0 2 0F 00000100 00000000 0 DEADBEEF  1 0F 1122EE44 0 0 00000000 00000000
1 1 1 5 1 0 1 10 00000106 00000000 0 DEADBEEF  1 10 00009988 0 0 00000000 00000000
// cacheable store through the bypass, then a bubble that must not write
1 1 0 0 0 0 0 11 0000AB5A 00000000 0 00000000  1 11 0000AB5A 0 0 00000000 00000000
1 0 0 0 1 1 2 00 00000208 00000000 1 00000000  0 00 00000208 0 0 00000000 00000000
0 1 0 0 1 1 2 11 00000208 FFFFFFFF 0 00000000  0 11 00000208 0 0 00000000 00000000
1 1 1 2 1 0 2 12 00000208 00000000 0 00000000  1 12 0000AB5A 0 0 00000000 00000000
1 1 1 0 1 0 0 13 00000209 00000000 0 00000000  1 13 FFFFFFAB 0 0 00000000 00000000
// uncached byte store leaves the banks alone
1 0 0 0 1 1 0 00 F0000031 00000077 0 00000000  0 00 F0000031 1 1 F0000031 00000077
1 1 1 2 1 0 2 14 00000104 00000000 0 00000000  1 14 9988C7D8 0 0 00000000 00000000

//--- mem_wb_top.f
hdl/core_mem_pkg.sv
hdl/core_mem_s.sv
hdl/l1d_lane_steer.sv
hdl/l1d_byte_bank.sv
hdl/core_wb_s.sv
hdl/mem_wb_top.sv
tb/mem_wb_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the mem_wb_top testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module mem_wb_top_tb -f mem_wb_top.f -o mem_wb_top_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mem_wb_top_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation returned status $sim_status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

//--- tb/mem_wb_top_tb.sv
// mem_wb_top_tb
// runs the access vectors of the stimulus file through the memory and
// write-back back end, with random stall cycles in between
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top_tb import core_mem_pkg::*; ();

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYC   = 16;
	localparam int NUM_VEC     = 28;
	// 12 stimulus columns followed by 7 expected columns
	localparam int NUM_FIELDS  = 19;
	localparam int TIMEOUT_CYC = RESET_CYC + 4 * NUM_VEC + 50;

	logic      clk;
	logic      rst_n;
	logic      mem_enb;
	logic      val_inst;
	logic      we_rf;
	logic      sel_mem;
	sx_op_t    sx_op;
	logic      req_val;
	logic      req_we;
	req_size_t req_size;
	reg_idx_t  rd;
	word_t     alu_result;
	word_t     store_data;
	logic      bp_sel;
	word_t     io_rdata;
	logic      io_req_val;
	logic      io_we;
	word_t     io_addr;
	word_t     io_wdata;
	logic      rf_we;
	reg_idx_t  rf_rd;
	word_t     rf_wdata;

	word_t       vec_mem [NUM_VEC * NUM_FIELDS];
	int          cycle_cnt = 0;
	int          vec_i;
	int          n_stall;
	logic [31:0] lcg_state;
	logic        have_prev;

	mem_wb_top uut (
		.clk(clk), .rst_n(rst_n), .mem_enb(mem_enb),
		.val_inst(val_inst), .we_rf(we_rf), .sel_mem(sel_mem), .sx_op(sx_op),
		.req_val(req_val), .req_we(req_we), .req_size(req_size), .rd(rd),
		.alu_result(alu_result), .store_data(store_data), .bp_sel(bp_sel),
		.io_rdata(io_rdata), .io_req_val(io_req_val), .io_we(io_we),
		.io_addr(io_addr), .io_wdata(io_wdata),
		.rf_we(rf_we), .rf_rd(rf_rd), .rf_wdata(rf_wdata)
	);

	always #(HALF_PERIOD) clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("simulation timed out after %0d cycles", cycle_cnt);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// stimulus columns of one vector except io read data, mem_enb held low
	task automatic drive_vector(input int idx);
		int b;
		b = idx * NUM_FIELDS;
		mem_enb    = 1'b0;
		val_inst   = vec_mem[b][0];
		we_rf      = vec_mem[b+1][0];
		sel_mem    = vec_mem[b+2][0];
		sx_op      = vec_mem[b+3][2:0];
		req_val    = vec_mem[b+4][0];
		req_we     = vec_mem[b+5][0];
		req_size   = vec_mem[b+6][2:0];
		rd         = vec_mem[b+7][4:0];
		alu_result = vec_mem[b+8];
		store_data = vec_mem[b+9];
		bp_sel     = vec_mem[b+10][0];
	endtask

	// io port in the accepting cycle
	task automatic check_io(input int idx);
		int b;
		b = idx * NUM_FIELDS;
		check_value($sformatf("vector %0d io_req_val", idx), vec_mem[b+15], 32'(io_req_val));
		if (vec_mem[b+15][0]) begin
			check_value($sformatf("vector %0d io_we", idx), vec_mem[b+16], 32'(io_we));
			check_value($sformatf("vector %0d io_addr", idx), vec_mem[b+17], io_addr);
			check_value($sformatf("vector %0d io_wdata", idx), vec_mem[b+18], io_wdata);
		end
	endtask

	// register file port one cycle after acceptance
	task automatic check_wb(input int idx);
		int b;
		b = idx * NUM_FIELDS;
		check_value($sformatf("vector %0d rf_we", idx), vec_mem[b+12], 32'(rf_we));
		check_value($sformatf("vector %0d rf_rd", idx), vec_mem[b+13], 32'(rf_rd));
		check_value($sformatf("vector %0d rf_wdata", idx), vec_mem[b+14], rf_wdata);
	endtask

	// write-back of the vector before idx, still on the port
	task automatic check_held_wb(input int idx, input string tag, input logic with_data);
		int b;
		b = (idx - 1) * NUM_FIELDS;
		check_value($sformatf("%s %0d rf_we", tag, idx), vec_mem[b+12], 32'(rf_we));
		check_value($sformatf("%s %0d rf_rd", tag, idx), vec_mem[b+13], 32'(rf_rd));
		if (with_data) begin
			check_value($sformatf("%s %0d rf_wdata", tag, idx), vec_mem[b+14], rf_wdata);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		mem_enb    = 1'b0;
		val_inst   = 1'b0;
		we_rf      = 1'b0;
		sel_mem    = 1'b0;
		sx_op      = '0;
		req_val    = 1'b0;
		req_we     = 1'b0;
		req_size   = '0;
		rd         = '0;
		alu_result = '0;
		store_data = '0;
		bp_sel     = 1'b0;
		io_rdata   = '0;
		lcg_state  = 32'd80056;
		have_prev  = 1'b0;
		$readmemh("tb/mem_wb_input.txt", vec_mem);
		repeat (RESET_CYC) @(negedge clk);
		rst_n = 1'b1;
		#(HALF_PERIOD / 2);
		check_value("reset rf_we", 32'd0, 32'(rf_we));
		check_value("reset io_req_val", 32'd0, 32'(io_req_val));
		@(negedge clk);
		for (vec_i = 0; vec_i < NUM_VEC; vec_i++) begin
			drive_vector(vec_i);
			lcg_state = lcg_next(lcg_state);
			n_stall = int'((lcg_state >> 16) % 32'd3);
			// stalled cycles show no strobe and keep the previous write-back
			repeat (n_stall) begin
				#(HALF_PERIOD / 2);
				check_value($sformatf("stall %0d io_req_val", vec_i), 32'd0, 32'(io_req_val));
				if (have_prev) begin
					check_held_wb(vec_i, "stall", 1'b1);
				end
				@(negedge clk);
			end
			// io read data stays up through this vector's write-back cycle
			mem_enb  = 1'b1;
			io_rdata = vec_mem[vec_i * NUM_FIELDS + 11];
			#(HALF_PERIOD / 2);
			check_io(vec_i);
			// previous rf_we and rf_rd last until the accepting edge
			if (have_prev) begin
				check_held_wb(vec_i, "accept", 1'b0);
			end
			@(negedge clk);
			check_wb(vec_i);
			have_prev = 1'b1;
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/mem_wb_top.sv
// mem_wb_top
// back end of the pipeline: memory stage, lane steering, l1d byte banks,
// write-back stage and the store data bypass loop
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top import core_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      mem_enb,
	// execute results
	input  logic      val_inst,
	input  logic      we_rf,
	input  logic      sel_mem,
	input  sx_op_t    sx_op,
	input  logic      req_val,
	input  logic      req_we,
	input  req_size_t req_size,
	input  reg_idx_t  rd,
	input  word_t     alu_result,
	input  word_t     store_data,
	input  logic      bp_sel,
	// uncached io port
	input  word_t     io_rdata,
	output logic      io_req_val,
	output logic      io_we,
	output word_t     io_addr,
	output word_t     io_wdata,
	// register file write port
	output logic      rf_we,
	output reg_idx_t  rf_rd,
	output word_t     rf_wdata
);

	// request from the stage
	logic      l1d_req_val;
	logic      l1d_req_we;
	req_size_t l1d_req_size;
	word_t     l1d_addr;
	word_t     l1d_wdata;
	logic      l1d_req_nc;
	logic      cache_req_val;

	// bank side
	logic                      lane_en;
	lane_idx_t                 lane_index;
	logic [NUM_LANES-1:0]      lane_we;
	logic [NUM_LANES-1:0][7:0] lane_wbyte;
	logic [NUM_LANES-1:0][7:0] lane_rbyte;

	// mem to wb
	logic       wb_val;
	logic       wb_we_rf;
	logic       wb_sel_mem;
	sx_op_t     wb_sx_op;
	reg_idx_t   wb_rd;
	word_t      wb_alu_result;
	logic [1:0] wb_byte_off;
	logic       wb_nc;

	// ----------------------------------------------------------------------
	// memory stage
	// ----------------------------------------------------------------------
	// store bypass comes back from rf_wdata
	core_mem_s u_mem (
		.clk(clk), .rst_n(rst_n), .mem_enb(mem_enb),
		.val_inst(val_inst), .we_rf(we_rf), .sel_mem(sel_mem), .sx_op(sx_op),
		.req_val(req_val), .req_we(req_we), .req_size(req_size), .rd(rd),
		.alu_result(alu_result), .store_data(store_data),
		.bp_sel(bp_sel), .bp_data(rf_wdata),
		.l1d_req_val(l1d_req_val), .l1d_req_we(l1d_req_we),
		.l1d_req_size(l1d_req_size), .l1d_addr(l1d_addr),
		.l1d_wdata(l1d_wdata), .l1d_req_nc(l1d_req_nc),
		.wb_val(wb_val), .wb_we_rf(wb_we_rf), .wb_sel_mem(wb_sel_mem),
		.wb_sx_op(wb_sx_op), .wb_rd(wb_rd), .wb_alu_result(wb_alu_result),
		.wb_byte_off(wb_byte_off), .wb_nc(wb_nc)
	);

	// no strobe fires during a stall
	assign cache_req_val = l1d_req_val & ~l1d_req_nc & mem_enb;
	assign io_req_val    = l1d_req_val & l1d_req_nc & mem_enb;
	assign io_we         = l1d_req_we;
	assign io_addr       = l1d_addr;
	assign io_wdata      = l1d_wdata;

	// ----------------------------------------------------------------------
	// l1d steering and banks
	// ----------------------------------------------------------------------
	l1d_lane_steer u_steer (
		.req_val(cache_req_val), .req_we(l1d_req_we), .req_size(l1d_req_size),
		.addr(l1d_addr), .wdata(l1d_wdata),
		.lane_en(lane_en), .lane_index(lane_index),
		.lane_we(lane_we), .lane_wbyte(lane_wbyte)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		l1d_byte_bank u_bank (
			.clk(clk), .rst_n(rst_n), .en(lane_en), .we(lane_we[g]),
			.index(lane_index), .wbyte(lane_wbyte[g]), .rbyte(lane_rbyte[g])
		);
	end

	// ----------------------------------------------------------------------
	// write-back stage
	// ----------------------------------------------------------------------
	core_wb_s u_wb (
		.wb_val(wb_val), .wb_we_rf(wb_we_rf), .wb_sel_mem(wb_sel_mem),
		.wb_sx_op(wb_sx_op), .wb_rd(wb_rd), .wb_alu_result(wb_alu_result),
		.wb_byte_off(wb_byte_off), .wb_nc(wb_nc),
		.lane_rbyte(lane_rbyte), .io_rdata(io_rdata),
		.rf_we(rf_we), .rf_rd(rf_rd), .rf_wdata(rf_wdata)
	);

endmodule

`default_nettype wire

//--- hdl/core_wb_s.sv
// core_wb_s
// write-back stage: gathers lane or io read data, aligns and extends it
// per load op and picks the register file write value
`timescale 1ns/1ps
`default_nettype none

module core_wb_s import core_mem_pkg::*; (
	// from mem stage registers
	input  logic                      wb_val,
	input  logic                      wb_we_rf,
	input  logic                      wb_sel_mem,
	input  sx_op_t                    wb_sx_op,
	input  reg_idx_t                  wb_rd,
	input  word_t                     wb_alu_result,
	input  logic [1:0]                wb_byte_off,
	input  logic                      wb_nc,
	// read data sources
	input  logic [NUM_LANES-1:0][7:0] lane_rbyte,
	input  word_t                     io_rdata,
	// register file write port
	output logic                      rf_we,
	output reg_idx_t                  rf_rd,
	output word_t                     rf_wdata
);

	word_t raw_word;
	word_t aligned;
	word_t load_val;

	// ----------------------------------------------------------------------
	// load data path
	// ----------------------------------------------------------------------
	// lane 0 is the low byte of the word
	assign raw_word = wb_nc ? io_rdata : word_t'(lane_rbyte);

	// addressed byte down to bit 0
	assign aligned = raw_word >> {wb_byte_off, 3'b000};

	always_comb begin
		case (wb_sx_op)
			SX_LB:   load_val = {{24{aligned[7]}}, aligned[7:0]};
			SX_LH:   load_val = {{16{aligned[15]}}, aligned[15:0]};
			SX_LW:   load_val = aligned;
			SX_LBU:  load_val = {24'h000000, aligned[7:0]};
			SX_LHU:  load_val = {16'h0000, aligned[15:0]};
			// unused funct3 codes pass the word
			default: load_val = aligned;
		endcase
	end

	// ----------------------------------------------------------------------
	// register file port
	// ----------------------------------------------------------------------
	// loaded value or alu result
	assign rf_wdata = wb_sel_mem ? load_val : wb_alu_result;

	// bubbles never write
	assign rf_we = wb_val & wb_we_rf;
	assign rf_rd = wb_rd;

endmodule

`default_nettype wire

//--- hdl/l1d_byte_bank.sv
// l1d_byte_bank
// one byte-wide lane of the l1d store, synchronous ram with a
// registered read port
`timescale 1ns/1ps
`default_nettype none

module l1d_byte_bank import core_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      en,
	input  logic      we,
	input  lane_idx_t index,
	input  logic [7:0] wbyte,
	output logic [7:0] rbyte
);

	// storage array
	logic [7:0] mem [BANK_DEPTH];

	// ----------------------------------------------------------------------
	// write port
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[index] <= wbyte;
		end
	end

	// ----------------------------------------------------------------------
	// read register
	// ----------------------------------------------------------------------
	// holds its byte until the next read strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rbyte <= 8'h00;
		end else if (en && !we) begin
			rbyte <= mem[index];
		end
	end

endmodule

`default_nettype wire

//--- hdl/l1d_lane_steer.sv
// l1d_lane_steer
// splits one cacheable request into per-lane write enables, lane bytes
// and the shared bank word index
`timescale 1ns/1ps
`default_nettype none

module l1d_lane_steer import core_mem_pkg::*; (
	input  logic                       req_val,
	input  logic                       req_we,
	input  req_size_t                  req_size,
	input  word_t                      addr,
	input  word_t                      wdata,
	output logic                       lane_en,
	output lane_idx_t                  lane_index,
	output logic [NUM_LANES-1:0]       lane_we,
	output logic [NUM_LANES-1:0][7:0]  lane_wbyte
);

	logic [NUM_LANES-1:0] byte_en;

	// every bank sees the strobe, unwritten lanes just read
	assign lane_en = req_val;

	// word address drops the byte offset
	assign lane_index = addr[LANE_ADDR_W+1:2];

	// ----------------------------------------------------------------------
	// byte enables from size and offset
	// ----------------------------------------------------------------------
	always_comb begin
		case (req_size)
			REQ_BYTE: byte_en = {{(NUM_LANES-1){1'b0}}, 1'b1} << addr[1:0];
			// half is aligned on bit 1
			REQ_HALF: byte_en = {{(NUM_LANES-2){1'b0}}, 2'b11} << {addr[1], 1'b0};
			REQ_WORD: byte_en = '1;
			default:  byte_en = '0;
		endcase
	end

	assign lane_we = (req_val && req_we) ? byte_en : '0;

	// ----------------------------------------------------------------------
	// store data replication
	// ----------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			case (req_size)
				// low byte onto every lane
				REQ_BYTE: lane_wbyte[i] = wdata[7:0];
				// low half onto both halves
				REQ_HALF: lane_wbyte[i] = wdata[8*(i%2) +: 8];
				default:  lane_wbyte[i] = wdata[8*i +: 8];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/core_mem_s.sv
// core_mem_s
// memory stage of the pipeline: classifies the address, picks the store
// word, issues the data request and registers the write-back fields
`timescale 1ns/1ps
`default_nettype none

module core_mem_s import core_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      mem_enb,
	// control from execute
	input  logic      val_inst,
	input  logic      we_rf,
	input  logic      sel_mem,
	input  sx_op_t    sx_op,
	input  logic      req_val,
	input  logic      req_we,
	input  req_size_t req_size,
	input  reg_idx_t  rd,
	// data from execute
	input  word_t     alu_result,
	input  word_t     store_data,
	// store data bypass from write-back
	input  logic      bp_sel,
	input  word_t     bp_data,
	// data request
	output logic      l1d_req_val,
	output logic      l1d_req_we,
	output req_size_t l1d_req_size,
	output word_t     l1d_addr,
	output word_t     l1d_wdata,
	output logic      l1d_req_nc,
	// mem to wb registers
	output logic      wb_val,
	output logic      wb_we_rf,
	output logic      wb_sel_mem,
	output sx_op_t    wb_sx_op,
	output reg_idx_t  wb_rd,
	output word_t     wb_alu_result,
	output logic [1:0] wb_byte_off,
	output logic      wb_nc
);

	// ----------------------------------------------------------------------
	// request side
	// ----------------------------------------------------------------------
	// address comes straight from the alu
	assign l1d_addr = alu_result;

	// bits outside the mask must match the window base
	assign l1d_req_nc = ((alu_result & ~NC_MASK) == NC_BASE);

	// only a valid instruction may issue
	assign l1d_req_val  = req_val & val_inst;
	assign l1d_req_we   = req_we;
	assign l1d_req_size = req_size;

	// store word, wb bypass wins when selected
	assign l1d_wdata = bp_sel ? bp_data : store_data;

	// ----------------------------------------------------------------------
	// mem to wb pipeline registers
	// ----------------------------------------------------------------------
	// control bits, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_val   <= 1'b0;
			wb_we_rf <= 1'b0;
		end else if (mem_enb) begin
			wb_val   <= val_inst;
			wb_we_rf <= we_rf;
		end
	end

	// payload, frozen while stalled
	always_ff @(posedge clk) begin
		if (mem_enb) begin
			wb_sel_mem    <= sel_mem;
			wb_sx_op      <= sx_op;
			wb_rd         <= rd;
			wb_alu_result <= alu_result;
			// low address bits pick the bytes on load
			wb_byte_off   <= alu_result[1:0];
			wb_nc         <= l1d_req_nc;
		end
	end

endmodule

`default_nettype wire

//--- hdl/core_mem_pkg.sv
// core_mem_pkg
// shared types and constants for the memory stage, the l1d byte banks
// and the write-back stage
`default_nettype none

package core_mem_pkg;

	// ----------------------------------------------------------------------
	// geometry
	// ----------------------------------------------------------------------
	// one bank per byte of a word
	localparam int NUM_LANES   = 4;
	// word index width per bank
	localparam int LANE_ADDR_W = 8;
	localparam int BANK_DEPTH  = 1 << LANE_ADDR_W;

	// ----------------------------------------------------------------------
	// vector types
	// ----------------------------------------------------------------------
	typedef logic [31:0]            word_t;
	typedef logic [4:0]             reg_idx_t;
	// load extension op, rv32 funct3 coding
	typedef logic [2:0]             sx_op_t;
	typedef logic [2:0]             req_size_t;
	typedef logic [LANE_ADDR_W-1:0] lane_idx_t;

	// load extension codes
	localparam sx_op_t SX_LB  = 3'd0;
	localparam sx_op_t SX_LH  = 3'd1;
	localparam sx_op_t SX_LW  = 3'd2;
	localparam sx_op_t SX_LBU = 3'd4;
	localparam sx_op_t SX_LHU = 3'd5;

	// access size codes
	localparam req_size_t REQ_BYTE = 3'd0;
	localparam req_size_t REQ_HALF = 3'd1;
	localparam req_size_t REQ_WORD = 3'd2;

	// ----------------------------------------------------------------------
	// uncached window
	// ----------------------------------------------------------------------
	// uncached when the bits outside the mask match the base
	localparam word_t NC_BASE = 32'hF000_0000;
	localparam word_t NC_MASK = 32'h0FFF_FFFF;

endpackage

`default_nettype wire
